// File: source/lz_summary_config.svh
`ifndef LZ_SUMMARY_CONFIG_SVH
`define LZ_SUMMARY_CONFIG_SVH

// lazy candidates per sequence head.
`define LAZY_LEN 4

// job geometry.
`define JOB_LEN 256
`define JOB_LEN_LOG2 8

// match length and forward step, wide enough for ml + ll + head.
`define MATCH_LEN_WIDTH 10

`define SEQ_OFFSET_BITS 16
`define SEQ_OFFSET_BITS_LOG2 5

// summary field widths.
`define SEQ_LL_BITS 10
`define SEQ_ML_BITS 10

`define GAIN_BITS 16

`endif

// File: source/lz_summary_pkg.sv
`default_nettype none

`include "lz_summary_config.svh"

package lz_summary_pkg;

    // position or distance inside a job.
    typedef logic [`JOB_LEN_LOG2-1:0] job_ptr_t;

    typedef logic [`MATCH_LEN_WIDTH-1:0] match_len_t; // also the forward step.

    typedef logic [`SEQ_OFFSET_BITS-1:0] seq_offset_t;

    // bit length of an offset, 0 to 16.
    typedef logic [`SEQ_OFFSET_BITS_LOG2-1:0] offset_cost_t;

    typedef logic signed [`GAIN_BITS-1:0] gain_t;

    // summary fields.
    typedef logic [`SEQ_LL_BITS-1:0] seq_ll_t;
    typedef logic [`SEQ_ML_BITS-1:0] seq_ml_t; // match length or overlap.

endpackage

`default_nettype wire

// File: source/candidate_cost_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "lz_summary_config.svh"

module candidate_cost_stage (
    input  wire                                             clk,
    input  wire                                             i_rst,
    input  wire                                             i_match_done,
    input  wire lz_summary_pkg::job_ptr_t                   i_match_head_ptr,
    input  wire lz_summary_pkg::job_ptr_t                   i_seq_head_ptr,
    input  wire                                             i_delim,
    input  wire [`LAZY_LEN-1:0]                             i_match_valid,
    input  wire lz_summary_pkg::match_len_t [`LAZY_LEN-1:0] i_match_len,
    input  wire lz_summary_pkg::seq_offset_t [`LAZY_LEN-1:0] i_offset,
    output logic                                            o_done,
    output lz_summary_pkg::job_ptr_t                        o_seq_head_ptr,
    output logic                                            o_delim,
    output logic [`LAZY_LEN-1:0]                            o_match_valid,
    output lz_summary_pkg::job_ptr_t [`LAZY_LEN-1:0]        o_ll,
    output lz_summary_pkg::match_len_t [`LAZY_LEN-1:0]      o_match_len,
    output lz_summary_pkg::seq_offset_t [`LAZY_LEN-1:0]     o_offset,
    output lz_summary_pkg::offset_cost_t [`LAZY_LEN-1:0]    o_offset_cost,
    output lz_summary_pkg::gain_t [`LAZY_LEN-1:0]           o_base_gain
);
    import lz_summary_pkg::*;

    job_ptr_t     [`LAZY_LEN-1:0] ll_c;
    offset_cost_t [`LAZY_LEN-1:0] cost_c;
    gain_t        [`LAZY_LEN-1:0] base_gain_c;

    // leading one search, index of the top set bit plus one.
    function automatic offset_cost_t offset_bit_len(input seq_offset_t offset);
        offset_cost_t len;
        len = '0;
        for (int b = 0; b < `SEQ_OFFSET_BITS; b++) begin
            if (offset[b]) len = offset_cost_t'(b + 1);
        end
        return len;
    endfunction

    always_comb begin
        for (int i = 0; i < `LAZY_LEN; i++) begin
            ll_c[i] = i_match_head_ptr - i_seq_head_ptr + job_ptr_t'(i); // wraps mod job.
            cost_c[i] = offset_bit_len(i_offset[i]);
            // earlier candidates get the larger bonus.
            base_gain_c[i] = gain_t'({i_match_len[i], 2'b00}) + gain_t'(4 * (`LAZY_LEN - i));
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) o_done <= 1'b0;
        else o_done <= i_match_done;
    end

    always_ff @(posedge clk) begin
        o_seq_head_ptr <= i_seq_head_ptr;
        o_delim        <= i_delim;
        o_match_valid  <= i_match_valid;
        o_ll           <= ll_c;
        o_match_len    <= i_match_len;
        o_offset       <= i_offset;
        o_offset_cost  <= cost_c;
        o_base_gain    <= base_gain_c;
    end

endmodule

`default_nettype wire

// File: source/candidate_gain_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "lz_summary_config.svh"

module candidate_gain_stage (
    input  wire                                               clk,
    input  wire                                               i_rst,
    input  wire                                               i_done,
    input  wire lz_summary_pkg::job_ptr_t                     i_seq_head_ptr,
    input  wire                                               i_delim,
    input  wire [`LAZY_LEN-1:0]                               i_match_valid,
    input  wire lz_summary_pkg::job_ptr_t [`LAZY_LEN-1:0]     i_ll,
    input  wire lz_summary_pkg::match_len_t [`LAZY_LEN-1:0]   i_match_len,
    input  wire lz_summary_pkg::seq_offset_t [`LAZY_LEN-1:0]  i_offset,
    input  wire lz_summary_pkg::offset_cost_t [`LAZY_LEN-1:0] i_offset_cost,
    input  wire lz_summary_pkg::gain_t [`LAZY_LEN-1:0]        i_base_gain,
    output logic                                              o_done,
    output lz_summary_pkg::job_ptr_t                          o_seq_head_ptr,
    output logic                                              o_delim,
    output logic [`LAZY_LEN-1:0]                              o_match_valid,
    output lz_summary_pkg::job_ptr_t [`LAZY_LEN-1:0]          o_ll,
    output lz_summary_pkg::match_len_t [`LAZY_LEN-1:0]        o_match_len,
    output lz_summary_pkg::seq_offset_t [`LAZY_LEN-1:0]       o_offset,
    output lz_summary_pkg::gain_t [`LAZY_LEN-1:0]             o_gain,
    output lz_summary_pkg::match_len_t [`LAZY_LEN-1:0]        o_move_forward
);
    import lz_summary_pkg::*;

    gain_t      [`LAZY_LEN-1:0] gain_c;
    match_len_t [`LAZY_LEN-1:0] move_forward_c;

    always_comb begin
        for (int i = 0; i < `LAZY_LEN; i++) begin
            gain_c[i] = i_base_gain[i] - gain_t'(i_offset_cost[i]); // offset bits cost.
            move_forward_c[i] = i_match_len[i] + match_len_t'(i_ll[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) o_done <= 1'b0;
        else o_done <= i_done;
    end

    always_ff @(posedge clk) begin
        o_seq_head_ptr <= i_seq_head_ptr;
        o_delim        <= i_delim;
        o_match_valid  <= i_match_valid;
        o_ll           <= i_ll;
        o_match_len    <= i_match_len;
        o_offset       <= i_offset;
        o_gain         <= gain_c;
        o_move_forward <= move_forward_c;
    end

endmodule

`default_nettype wire

// File: source/best_match_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "lz_summary_config.svh"

module best_match_select (
    input  wire                                              clk,
    input  wire                                              i_rst,
    input  wire                                              i_done,
    input  wire lz_summary_pkg::job_ptr_t                    i_seq_head_ptr,
    input  wire                                              i_delim,
    input  wire [`LAZY_LEN-1:0]                              i_match_valid,
    input  wire lz_summary_pkg::job_ptr_t [`LAZY_LEN-1:0]    i_ll,
    input  wire lz_summary_pkg::match_len_t [`LAZY_LEN-1:0]  i_match_len,
    input  wire lz_summary_pkg::seq_offset_t [`LAZY_LEN-1:0] i_offset,
    input  wire lz_summary_pkg::gain_t [`LAZY_LEN-1:0]       i_gain,
    input  wire lz_summary_pkg::match_len_t [`LAZY_LEN-1:0]  i_move_forward,
    output logic                                             o_done,
    output lz_summary_pkg::job_ptr_t                         o_seq_head_ptr,
    output logic                                             o_delim,
    output lz_summary_pkg::job_ptr_t                         o_ll,
    output lz_summary_pkg::match_len_t                       o_match_len,
    output lz_summary_pkg::seq_offset_t                      o_offset,
    output lz_summary_pkg::match_len_t                       o_move_forward
);
    import lz_summary_pkg::*;

    logic        best_valid;
    gain_t       best_gain;
    job_ptr_t    best_ll;
    match_len_t  best_ml;
    seq_offset_t best_offset;
    match_len_t  best_mf;

    // strict compare so a tie keeps the lower index.
    always_comb begin
        best_valid  = i_match_valid[0];
        best_gain   = i_gain[0];
        best_ll     = i_ll[0];
        best_ml     = i_match_len[0];
        best_offset = i_offset[0];
        best_mf     = i_move_forward[0];
        for (int i = 1; i < `LAZY_LEN; i++) begin
            if (i_match_valid[i] && (!best_valid || $signed(i_gain[i]) > best_gain)) begin
                best_valid  = 1'b1;
                best_gain   = i_gain[i];
                best_ll     = i_ll[i];
                best_ml     = i_match_len[i];
                best_offset = i_offset[i];
                best_mf     = i_move_forward[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) o_done <= 1'b0;
        else o_done <= i_done;
    end

    always_ff @(posedge clk) begin
        o_seq_head_ptr <= i_seq_head_ptr;
        o_delim        <= i_delim;
        o_ll           <= best_ll;
        o_match_len    <= best_ml;
        o_offset       <= best_offset;
        o_move_forward <= best_mf;
    end

    // winner fields must come from one candidate.
    a_step_matches_winner: assert property (@(posedge clk) disable iff (i_rst)
        o_done |-> o_move_forward == match_len_t'(o_match_len + match_len_t'(o_ll)));

endmodule

`default_nettype wire

// File: source/job_boundary_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "lz_summary_config.svh"

module job_boundary_stage (
    input  wire                               clk,
    input  wire                               i_rst,
    input  wire                               i_done,
    input  wire lz_summary_pkg::job_ptr_t     i_seq_head_ptr,
    input  wire                               i_delim,
    input  wire lz_summary_pkg::job_ptr_t     i_ll,
    input  wire lz_summary_pkg::match_len_t   i_match_len,
    input  wire lz_summary_pkg::seq_offset_t  i_offset,
    input  wire lz_summary_pkg::match_len_t   i_move_forward,
    output logic                              o_summary_done,
    output lz_summary_pkg::job_ptr_t          o_seq_head_ptr,
    output lz_summary_pkg::seq_ll_t           o_summary_ll,
    output lz_summary_pkg::seq_ml_t           o_summary_ml,
    output lz_summary_pkg::seq_offset_t       o_summary_offset,
    output logic                              o_summary_delim,
    output logic                              o_summary_eoj,
    output lz_summary_pkg::seq_ml_t           o_summary_overlap_len,
    output logic                              o_move_to_next_job,
    output lz_summary_pkg::job_ptr_t          o_move_forward
);
    import lz_summary_pkg::*;

    // one spare bit so the sign survives ml + ll + head.
    localparam int OVL_W = `MATCH_LEN_WIDTH + 1;

    logic signed [OVL_W-1:0] overlap;
    logic                    crosses_end;

    assign overlap = OVL_W'(i_move_forward) + OVL_W'(i_seq_head_ptr) - OVL_W'(`JOB_LEN);
    assign crosses_end = !overlap[OVL_W-1]; // overlap >= 0.

    always_ff @(posedge clk) begin
        if (i_rst) o_summary_done <= 1'b0;
        else o_summary_done <= i_done;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // end of job handling
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        o_seq_head_ptr  <= i_seq_head_ptr;
        o_summary_delim <= i_delim;
        if (crosses_end && i_delim) begin
            // last block, the tail becomes pure literals.
            o_summary_ll          <= seq_ll_t'(`JOB_LEN) - seq_ll_t'(i_seq_head_ptr);
            o_summary_ml          <= '0;
            o_summary_offset      <= '0;
            o_summary_eoj         <= 1'b1;
            o_summary_overlap_len <= '0;
            o_move_to_next_job    <= 1'b1;
            o_move_forward        <= '0;
        end else if (crosses_end) begin
            o_summary_ll          <= seq_ll_t'(i_ll);
            o_summary_ml          <= seq_ml_t'(i_match_len);
            o_summary_offset      <= i_offset;
            o_summary_eoj         <= 1'b1;
            o_summary_overlap_len <= seq_ml_t'(overlap); // spill into next job.
            o_move_to_next_job    <= 1'b1;
            o_move_forward        <= '0;
        end else begin
            o_summary_ll          <= seq_ll_t'(i_ll);
            o_summary_ml          <= seq_ml_t'(i_match_len);
            o_summary_offset      <= i_offset;
            o_summary_eoj         <= 1'b0;
            o_summary_overlap_len <= '0;
            o_move_to_next_job    <= 1'b0;
            o_move_forward        <= job_ptr_t'(i_move_forward);
        end
    end

    a_eoj_no_step: assert property (@(posedge clk) disable iff (i_rst)
        (o_summary_done && o_summary_eoj) |-> o_move_forward == '0);

    a_done_known: assert property (@(posedge clk) disable iff (i_rst)
        !$isunknown(o_summary_done));

endmodule

`default_nettype wire

// File: source/lazy_summary_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "lz_summary_config.svh"

module lazy_summary_top (
    input  wire                                              clk,
    input  wire                                              i_rst,
    input  wire                                              i_match_done,
    input  wire lz_summary_pkg::job_ptr_t                    i_match_head_ptr,
    input  wire lz_summary_pkg::job_ptr_t                    i_seq_head_ptr,
    input  wire                                              i_delim,
    input  wire [`LAZY_LEN-1:0]                              i_match_valid,
    input  wire lz_summary_pkg::match_len_t [`LAZY_LEN-1:0]  i_match_len,
    input  wire lz_summary_pkg::seq_offset_t [`LAZY_LEN-1:0] i_offset,
    output wire                                              o_summary_done,
    output wire lz_summary_pkg::job_ptr_t                    o_seq_head_ptr,
    output wire lz_summary_pkg::seq_ll_t                     o_summary_ll,
    output wire lz_summary_pkg::seq_ml_t                     o_summary_ml,
    output wire lz_summary_pkg::seq_offset_t                 o_summary_offset,
    output wire                                              o_summary_delim,
    output wire                                              o_summary_eoj,
    output wire lz_summary_pkg::seq_ml_t                     o_summary_overlap_len,
    output wire                                              o_move_to_next_job,
    output wire lz_summary_pkg::job_ptr_t                    o_move_forward
);
    import lz_summary_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage wires, sN is the output of stage N
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    wire                                s0_done, s1_done, s2_done;
    wire job_ptr_t                      s0_seq_head_ptr, s1_seq_head_ptr, s2_seq_head_ptr;
    wire                                s0_delim, s1_delim, s2_delim;
    wire [`LAZY_LEN-1:0]                s0_match_valid, s1_match_valid;
    wire job_ptr_t     [`LAZY_LEN-1:0]  s0_ll, s1_ll;
    wire match_len_t   [`LAZY_LEN-1:0]  s0_match_len, s1_match_len;
    wire seq_offset_t  [`LAZY_LEN-1:0]  s0_offset, s1_offset;
    wire offset_cost_t [`LAZY_LEN-1:0]  s0_offset_cost;
    wire gain_t        [`LAZY_LEN-1:0]  s0_base_gain, s1_gain;
    wire match_len_t   [`LAZY_LEN-1:0]  s1_move_forward;
    wire job_ptr_t                      s2_ll;
    wire match_len_t                    s2_match_len, s2_move_forward;
    wire seq_offset_t                   s2_offset;

    candidate_cost_stage cost_stage_i (
        .clk(clk), .i_rst(i_rst),
        .i_match_done(i_match_done), .i_match_head_ptr(i_match_head_ptr),
        .i_seq_head_ptr(i_seq_head_ptr), .i_delim(i_delim),
        .i_match_valid(i_match_valid), .i_match_len(i_match_len), .i_offset(i_offset),
        .o_done(s0_done), .o_seq_head_ptr(s0_seq_head_ptr), .o_delim(s0_delim),
        .o_match_valid(s0_match_valid), .o_ll(s0_ll), .o_match_len(s0_match_len),
        .o_offset(s0_offset), .o_offset_cost(s0_offset_cost), .o_base_gain(s0_base_gain)
    );

    candidate_gain_stage gain_stage_i (
        .clk(clk), .i_rst(i_rst),
        .i_done(s0_done), .i_seq_head_ptr(s0_seq_head_ptr), .i_delim(s0_delim),
        .i_match_valid(s0_match_valid), .i_ll(s0_ll), .i_match_len(s0_match_len),
        .i_offset(s0_offset), .i_offset_cost(s0_offset_cost), .i_base_gain(s0_base_gain),
        .o_done(s1_done), .o_seq_head_ptr(s1_seq_head_ptr), .o_delim(s1_delim),
        .o_match_valid(s1_match_valid), .o_ll(s1_ll), .o_match_len(s1_match_len),
        .o_offset(s1_offset), .o_gain(s1_gain), .o_move_forward(s1_move_forward)
    );

    best_match_select select_stage_i (
        .clk(clk), .i_rst(i_rst),
        .i_done(s1_done), .i_seq_head_ptr(s1_seq_head_ptr), .i_delim(s1_delim),
        .i_match_valid(s1_match_valid), .i_ll(s1_ll), .i_match_len(s1_match_len),
        .i_offset(s1_offset), .i_gain(s1_gain), .i_move_forward(s1_move_forward),
        .o_done(s2_done), .o_seq_head_ptr(s2_seq_head_ptr), .o_delim(s2_delim),
        .o_ll(s2_ll), .o_match_len(s2_match_len), .o_offset(s2_offset),
        .o_move_forward(s2_move_forward)
    );

    job_boundary_stage boundary_stage_i (
        .clk(clk), .i_rst(i_rst),
        .i_done(s2_done), .i_seq_head_ptr(s2_seq_head_ptr), .i_delim(s2_delim),
        .i_ll(s2_ll), .i_match_len(s2_match_len), .i_offset(s2_offset),
        .i_move_forward(s2_move_forward),
        .o_summary_done(o_summary_done), .o_seq_head_ptr(o_seq_head_ptr),
        .o_summary_ll(o_summary_ll), .o_summary_ml(o_summary_ml),
        .o_summary_offset(o_summary_offset), .o_summary_delim(o_summary_delim),
        .o_summary_eoj(o_summary_eoj), .o_summary_overlap_len(o_summary_overlap_len),
        .o_move_to_next_job(o_move_to_next_job), .o_move_forward(o_move_forward)
    );

endmodule

`default_nettype wire

// File: dv/lazy_summary_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lz_summary_config.svh"

module lazy_summary_tb;
    import lz_summary_pkg::*;

    localparam int TIMEOUT_CYCLES = 1200; // ~320 sets, gaps and drain.
    localparam int DRAIN_CYCLES = 8; // pipeline depth plus margin.

    typedef struct packed {
        job_ptr_t    head;
        seq_ll_t     ll;
        seq_ml_t     ml;
        seq_offset_t offset;
        logic        delim;
        logic        eoj;
        seq_ml_t     overlap;
        logic        next_job;
        job_ptr_t    step;
    } summary_t;

    logic clk = 1'b0;
    logic i_rst, i_match_done, i_delim;
    job_ptr_t i_match_head_ptr, i_seq_head_ptr;
    logic [`LAZY_LEN-1:0] i_match_valid;
    match_len_t [`LAZY_LEN-1:0] i_match_len, cand_ml;
    seq_offset_t [`LAZY_LEN-1:0] i_offset, cand_off;
    wire o_summary_done, o_summary_delim, o_summary_eoj, o_move_to_next_job;
    wire job_ptr_t o_seq_head_ptr, o_move_forward;
    wire seq_ll_t o_summary_ll;
    wire seq_ml_t o_summary_ml, o_summary_overlap_len;
    wire seq_offset_t o_summary_offset;

    summary_t expect_q[$];
    int issue_q[$];
    summary_t want;
    int issued;
    int cycle_count = 0;
    int check_count = 0;
    int error_count = 0;
    int errors_at_start = 0;
    int test_num = 0;
    integer seed = 57453;

    lazy_summary_top dut_i (.*);

    always #10 clk = ~clk;

    function automatic summary_t ref_summary(input job_ptr_t mhp, input job_ptr_t shp,
            input logic delim, input logic [`LAZY_LEN-1:0] valid,
            input match_len_t [`LAZY_LEN-1:0] ml, input seq_offset_t [`LAZY_LEN-1:0] off);
        summary_t s;
        int ll_v[`LAZY_LEN];
        int gain_v[`LAZY_LEN];
        int cost, v, best, mf, ovl;
        best = 0;
        for (int i = 0; i < `LAZY_LEN; i++) begin
            ll_v[i] = (int'(mhp) - int'(shp) + i + 2 * `JOB_LEN) % `JOB_LEN;
            cost = 0;
            v = int'(off[i]);
            while (v != 0) begin
                cost++;
                v = v >> 1;
            end
            gain_v[i] = 4 * int'(ml[i]) + 4 * (`LAZY_LEN - i) - cost;
            if (i > 0 && valid[i] && (!valid[best] || gain_v[i] > gain_v[best])) best = i;
        end
        mf = int'(ml[best]) + ll_v[best];
        ovl = mf + int'(shp) - `JOB_LEN;
        s.head = shp;
        s.delim = delim;
        s.ll = seq_ll_t'(ll_v[best]);
        s.ml = seq_ml_t'(ml[best]);
        s.offset = off[best];
        s.eoj = (ovl >= 0);
        s.next_job = (ovl >= 0);
        s.overlap = (ovl >= 0 && !delim) ? seq_ml_t'(ovl) : '0;
        s.step = (ovl >= 0) ? '0 : job_ptr_t'(mf % `JOB_LEN);
        if (ovl >= 0 && delim) begin
            s.ll = seq_ll_t'(`JOB_LEN - int'(shp)); // tail goes out as literals.
            s.ml = '0;
            s.offset = '0;
        end
        return s;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
            input logic [31:0] exp_val);
        check_count++;
        if (got !== exp_val) begin
            error_count++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp_val);
        end
    endtask

    // stage inputs from cand_ml and cand_off.
    task automatic send_set(input job_ptr_t mhp, input job_ptr_t shp, input logic delim,
            input logic [`LAZY_LEN-1:0] valid);
        @(posedge clk);
        #1;
        i_match_done = 1'b1;
        i_match_head_ptr = mhp;
        i_seq_head_ptr = shp;
        i_delim = delim;
        i_match_valid = valid;
        i_match_len = cand_ml;
        i_offset = cand_off;
        expect_q.push_back(ref_summary(mhp, shp, delim, valid, cand_ml, cand_off));
        issue_q.push_back(cycle_count);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            i_match_done = 1'b0;
        end
    endtask

    task automatic finish_test(input string name);
        int waited;
        waited = 0;
        idle(1);
        while (expect_q.size() != 0 && waited < DRAIN_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        test_num++;
        $display("test %0d, %s: %0d errors", test_num, name, error_count - errors_at_start);
        errors_at_start = error_count;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    // outputs are sampled mid-cycle.
    always @(negedge clk) begin
        if (!i_rst && o_summary_done === 1'b1) begin
            if (expect_q.size() == 0) begin
                error_count++;
                $display("summary done strobe arrived with no summary expected");
            end else begin
                want = expect_q.pop_front();
                issued = issue_q.pop_front();
                check_count++;
                if (cycle_count - issued != 4) begin
                    error_count++;
                    $display("summary arrived %0d cycles after its strobe, not 4",
                             cycle_count - issued);
                end
                compare_field("o_seq_head_ptr", o_seq_head_ptr, want.head);
                compare_field("o_summary_ll", o_summary_ll, want.ll);
                compare_field("o_summary_ml", o_summary_ml, want.ml);
                compare_field("o_summary_offset", o_summary_offset, want.offset);
                compare_field("o_summary_delim", o_summary_delim, want.delim);
                compare_field("o_summary_eoj", o_summary_eoj, want.eoj);
                compare_field("o_summary_overlap_len", o_summary_overlap_len, want.overlap);
                compare_field("o_move_to_next_job", o_move_to_next_job, want.next_job);
                compare_field("o_move_forward", o_move_forward, want.step);
            end
        end
    end

    initial begin
        logic [`LAZY_LEN-1:0] rnd_valid;
        job_ptr_t rnd_mhp, rnd_shp;
        logic rnd_delim;
        i_rst = 1'b1;
        i_match_done = 1'b0;
        i_match_head_ptr = '0;
        i_seq_head_ptr = '0;
        i_delim = 1'b0;
        i_match_valid = '0;
        i_match_len = '0;
        i_offset = '0;
        cand_ml = '0;
        cand_off = '0;
        repeat (5) @(posedge clk);
        #1 i_rst = 1'b0;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // directed tests
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        repeat (8) begin
            @(negedge clk);
            compare_field("o_summary_done", o_summary_done, 1'b0);
        end
        cand_ml[0] = 20;
        cand_off[0] = 16'h0040;
        send_set(8'd10, 8'd4, 1'b0, 4'b0001);
        finish_test("reset and single match");

        cand_ml = {10'd0, 10'd0, 10'd11, 10'd10}; // equal gains.
        cand_off = {16'h0, 16'h0, 16'h0010, 16'h0010};
        send_set(8'd0, 8'd0, 1'b0, 4'b0011);
        cand_ml = {10'd0, 10'd30, 10'd0, 10'd10};
        send_set(8'd0, 8'd0, 1'b0, 4'b0101);
        cand_ml = {10'd200, 10'd40, 10'd12, 10'd90};
        send_set(8'd3, 8'd0, 1'b0, 4'b0110);
        send_set(8'd7, 8'd2, 1'b0, 4'b0000);
        finish_test("selection");

        cand_ml = {10'd0, 10'd0, 10'd10, 10'd10};
        cand_off = {16'h0, 16'h0, 16'h0000, 16'hffff};
        send_set(8'd5, 8'd0, 1'b0, 4'b0011);
        cand_ml = {10'd0, 10'd0, 10'd11, 10'd10};
        cand_off = {16'h0, 16'h0, 16'h8000, 16'h0001};
        send_set(8'd5, 8'd0, 1'b0, 4'b0011);
        cand_ml = {10'd0, 10'd0, 10'd10, 10'd10};
        cand_off = {16'h0, 16'h0, 16'h0003, 16'h0100};
        send_set(8'd5, 8'd0, 1'b0, 4'b0011);
        finish_test("offset cost");

        cand_ml = {10'd0, 10'd0, 10'd0, 10'd60};
        cand_off = {16'h0, 16'h0, 16'h0, 16'h0123};
        send_set(8'd210, 8'd200, 1'b0, 4'b0001); // crosses by 14.
        cand_ml[0] = 50;
        send_set(8'd206, 8'd200, 1'b0, 4'b0001); // ends exactly at the job end.
        cand_ml[0] = 49;
        send_set(8'd206, 8'd200, 1'b0, 4'b0001);
        finish_test("end of job without delimiter");

        cand_ml[0] = 60;
        send_set(8'd210, 8'd200, 1'b1, 4'b0001);
        cand_ml[0] = 20;
        send_set(8'd210, 8'd200, 1'b1, 4'b0001);
        finish_test("end of job with delimiter");

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // random stream
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        for (int n = 0; n < 300; n++) begin
            for (int i = 0; i < `LAZY_LEN; i++) begin
                cand_ml[i] = match_len_t'($unsigned($random(seed)) % 512);
                cand_off[i] = seq_offset_t'($random(seed)) >> ($unsigned($random(seed)) % 16);
            end
            rnd_mhp = job_ptr_t'($random(seed));
            rnd_shp = job_ptr_t'($random(seed));
            rnd_delim = (($random(seed) & 7) == 0);
            rnd_valid = `LAZY_LEN'($random(seed));
            send_set(rnd_mhp, rnd_shp, rnd_delim, rnd_valid);
            if (($random(seed) & 3) == 0) idle(1 + $unsigned($random(seed)) % 3);
        end
        finish_test("random stream");

        if (expect_q.size() != 0) begin
            error_count++;
            $display("%0d expected summaries never came out", expect_q.size());
        end
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+source
source/lz_summary_pkg.sv
source/candidate_cost_stage.sv
source/candidate_gain_stage.sv
source/best_match_select.sv
source/job_boundary_stage.sv
source/lazy_summary_top.sv
dv/lazy_summary_tb.sv
